/* sim.f */
+incdir+include
logic/bus_types_pkg.sv
logic/bus_target_pkg.sv
logic/bus_decode.sv
logic/bus_target.sv
logic/bus_resp_merge.sv
logic/bus_fabric_top.sv
verif/bus_fabric_tb.sv

/* Bender.yml */
package:
  name: bus_fabric

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - logic/bus_types_pkg.sv
      - logic/bus_target_pkg.sv
      - logic/bus_decode.sv
      - logic/bus_target.sv
      - logic/bus_resp_merge.sv
      - logic/bus_fabric_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/bus_fabric_tb.sv

/* verif/bus_fabric_tb.sv */
// directed testbench for the bus fabric, with reference memory model and watchdog

`timescale 1ns/10ps
`default_nettype none

`include "mmap_cfg.svh"

module bus_fabric_tb
  import bus_types_pkg::*;
  import bus_target_pkg::*;
();

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int READY_LIMIT  = 20;
  // reset reads, full word, partial strobe, unmapped and random requests
  localparam int NUM_REQUESTS = 16 + 8 + 36 + 12 + 200;
  localparam int WATCHDOG_NS  = (NUM_REQUESTS * READY_LIMIT + RESET_CYCLES) * CLK_PERIOD;

  localparam logic [7:0] REGION_BASE [`TGT_NUM] = '{
    `NATV_IP_START, `APB_START, `PSRAM_START, `SPISD_START
  };
  localparam int REGION_WAIT [`TGT_NUM] = '{
    `NATV_WAIT, `APB_WAIT, `PSRAM_WAIT, `SPISD_WAIT
  };
  // top bytes that no region claims
  localparam logic [7:0] UNMAPPED_TOP [3] = '{8'h00, 8'h50, 8'hff};

  logic  clk;
  logic  arst_n;
  logic  core_valid;
  addr_t core_addr;
  data_t core_wdata;
  strb_t core_wstrb;
  data_t core_rdata;
  logic  core_ready;

  // expected contents of every target memory
  data_t  ref_mem [`TGT_NUM][`TGT_DEPTH];
  int     check_count;
  int     mismatch_count;
  int     error_count;
  integer seed;

  bus_fabric_top u_bus_fabric_top (
    .clk_i        (clk),
    .arst_n_i     (arst_n),
    .core_valid_i (core_valid),
    .core_addr_i  (core_addr),
    .core_wdata_i (core_wdata),
    .core_wstrb_i (core_wstrb),
    .core_rdata_o (core_rdata),
    .core_ready_o (core_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // -1 when no region claims the top byte
  function automatic int region_index(input addr_t addr);
    int idx;
    idx = -1;
    for (int k = 0; k < `TGT_NUM; k++) begin
      if (addr[31:24] == REGION_BASE[k]) begin
        idx = k;
      end
    end
    return idx;
  endfunction

  function automatic data_t merge_bytes(input data_t old_word, input data_t new_word,
                                        input strb_t strb);
    data_t merged;
    merged = old_word;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_word[8*b +: 8];
      end
    end
    return merged;
  endfunction

  function automatic addr_t make_addr(input logic [7:0] top, input logic [15:0] mid,
                                      input word_idx_t widx);
    return {top, mid, widx, 2'b00};
  endfunction

  task automatic check_data(input addr_t addr, input data_t exp, input data_t act);
    check_count++;
    if (act !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: read data, addr %h expected %h actual %h",
               $time, addr, exp, act);
    end
  endtask

  task automatic check_latency(input addr_t addr, input wait_cnt_t exp, input wait_cnt_t act);
    check_count++;
    if (act !== exp) begin
      mismatch_count++;
      $display("MISMATCH at %0t: latency, addr %h expected %0d actual %0d",
               $time, addr, exp, act);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // called at a falling edge and returns at the falling edge after the transfer
  task automatic bus_access(input addr_t addr, input data_t wdata, input strb_t strb,
                            output data_t rdata, output wait_cnt_t latency,
                            output logic got_ready);
    int cycles;
    cycles     = 0;
    got_ready  = 1'b0;
    rdata      = '0;
    core_valid = 1'b1;
    core_addr  = addr;
    core_wdata = wdata;
    core_wstrb = strb;
    while (!got_ready && cycles < READY_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (core_ready === 1'b1) begin
        got_ready = 1'b1;
        rdata     = core_rdata;
      end
    end
    // saturates above the counter range
    latency = (cycles > 15) ? '1 : wait_cnt_t'(cycles);
    if (!got_ready) begin
      error_count++;
      $display("ERROR at %0t: no ready for request to addr %h", $time, addr);
    end
    // request held through the edge that completes the transfer
    @(negedge clk);
    if (got_ready && core_ready !== 1'b0) begin
      mismatch_count++;
      $display("MISMATCH at %0t: ready longer than one cycle, addr %h expected 0 actual %b",
               $time, addr, core_ready);
    end
    core_valid = 1'b0;
    core_wstrb = '0;
  endtask

  // one access checked against the model before the model takes the write
  task automatic checked_access(input addr_t addr, input data_t wdata, input strb_t strb);
    int        region;
    data_t     exp_rdata;
    wait_cnt_t exp_latency;
    data_t     rdata;
    wait_cnt_t latency;
    logic      got_ready;
    region = region_index(addr);
    if (region >= 0) begin
      exp_rdata   = ref_mem[region][addr[7:2]];
      exp_latency = wait_cnt_t'(REGION_WAIT[region] + 1);
    end else begin
      exp_rdata   = `UNMAPPED_RDATA;
      exp_latency = wait_cnt_t'(1);
    end
    bus_access(addr, wdata, strb, rdata, latency, got_ready);
    if (got_ready) begin
      check_data(addr, exp_rdata, rdata);
      check_latency(addr, exp_latency, latency);
    end
    if (region >= 0 && strb != '0) begin
      ref_mem[region][addr[7:2]] = merge_bytes(ref_mem[region][addr[7:2]], wdata, strb);
    end
  endtask

  task automatic test_reset_state();
    for (int c = 0; c < 8; c++) begin
      @(negedge clk);
      if (core_ready !== 1'b0) begin
        mismatch_count++;
        $display("MISMATCH at %0t: ready with no request expected 0 actual %b",
                 $time, core_ready);
      end
    end
    for (int k = 0; k < `TGT_NUM; k++) begin
      for (int w = 0; w < 4; w++) begin
        checked_access(make_addr(REGION_BASE[k], 16'h0, word_idx_t'(w * 21)), '0, '0);
      end
    end
  endtask

  task automatic test_full_word();
    addr_t addr;
    for (int k = 0; k < `TGT_NUM; k++) begin
      addr = make_addr(REGION_BASE[k], 16'h0, word_idx_t'(5));
      checked_access(addr, data_t'($random(seed)), 4'hf);
      checked_access(addr, '0, '0);
    end
  endtask

  task automatic test_partial_strobe();
    strb_t strobes [4];
    addr_t addr;
    strobes = '{4'b0001, 4'b0100, 4'b0011, 4'b1100};
    for (int k = 0; k < `TGT_NUM; k++) begin
      addr = make_addr(REGION_BASE[k], 16'h0, word_idx_t'(9));
      checked_access(addr, 32'h1122_3344 + k, 4'hf);
      // each write also shows the old word in its ready cycle
      for (int s = 0; s < 4; s++) begin
        checked_access(addr, data_t'($random(seed)), strobes[s]);
        checked_access(addr, '0, '0);
      end
    end
  endtask

  task automatic test_unmapped();
    checked_access(make_addr(8'h50, 16'h0, word_idx_t'(2)), 32'hcafe_f00d, 4'hf);
    checked_access(make_addr(8'h50, 16'h0, word_idx_t'(2)), '0, '0);
    checked_access(make_addr(8'h00, 16'h0, word_idx_t'(9)), 32'h0bad_0bad, 4'b0011);
    checked_access(make_addr(8'hff, 16'h0, word_idx_t'(9)), '0, '0);
    // same word indexes in every region must be unchanged
    for (int k = 0; k < `TGT_NUM; k++) begin
      checked_access(make_addr(REGION_BASE[k], 16'h0, word_idx_t'(2)), '0, '0);
      checked_access(make_addr(REGION_BASE[k], 16'h0, word_idx_t'(9)), '0, '0);
    end
  endtask

  task automatic test_random();
    int         r;
    logic [7:0] top;
    strb_t      strb;
    for (int n = 0; n < 200; n++) begin
      r = $unsigned($random(seed)) % 5;
      if (r < `TGT_NUM) begin
        top = REGION_BASE[r];
      end else begin
        top = UNMAPPED_TOP[$unsigned($random(seed)) % 3];
      end
      // roughly half reads
      strb = ($random(seed) & 1) ? strb_t'($random(seed)) : '0;
      checked_access(make_addr(top, 16'($random(seed)), word_idx_t'($random(seed))),
                     data_t'($random(seed)), strb);
      idle_cycles($unsigned($random(seed)) % 4);
    end
  endtask

  initial begin
    seed           = 32'h99b4f03f;
    check_count    = 0;
    mismatch_count = 0;
    error_count    = 0;
    for (int k = 0; k < `TGT_NUM; k++) begin
      for (int i = 0; i < `TGT_DEPTH; i++) begin
        ref_mem[k][i] = '0;
      end
    end
    core_valid = 1'b0;
    core_addr  = '0;
    core_wdata = '0;
    core_wstrb = '0;
    arst_n     = 1'b0;
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    @(negedge clk);
    test_reset_state();
    test_full_word();
    test_partial_strobe();
    test_unmapped();
    test_random();
    $display("checks %0d, mismatches %0d, other errors %0d",
             check_count, mismatch_count, error_count);
    if (mismatch_count == 0 && error_count == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // watchdog
  initial begin
    #(WATCHDOG_NS);
    error_count++;
    $display("ERROR: timeout, the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("checks %0d, mismatches %0d, other errors %0d",
             check_count, mismatch_count, error_count);
    $display("Regression failed");
    $finish;
  end

endmodule

`default_nettype wire

/* logic/bus_fabric_top.sv */
// fabric top with decoder, target array and response merger

`timescale 1ns/10ps
`default_nettype none

`include "mmap_cfg.svh"

module bus_fabric_top
  import bus_types_pkg::*;
(
  input  logic  clk_i,
  input  logic  arst_n_i,
  // core native memory port
  input  logic  core_valid_i,
  input  addr_t core_addr_i,
  input  data_t core_wdata_i,
  input  strb_t core_wstrb_i,
  output data_t core_rdata_o,
  output logic  core_ready_o
);

  // wait cycles per target, same order as the region table
  localparam int unsigned TGT_WAIT [`TGT_NUM] = '{
    `NATV_WAIT,
    `APB_WAIT,
    `PSRAM_WAIT,
    `SPISD_WAIT
  };

  tgt_sel_t             tgt_valid;
  tgt_sel_t             tgt_ready;
  data_t [`TGT_NUM-1:0] tgt_rdata;
  logic                 unmapped_valid;

  bus_decode u_bus_decode (
    .core_valid_i     (core_valid_i),
    .core_addr_i      (core_addr_i),
    .tgt_valid_o      (tgt_valid),
    .unmapped_valid_o (unmapped_valid)
  );

  // address, data and strobe fan out to every target
  for (genvar k = 0; k < `TGT_NUM; k++) begin : g_tgt
    bus_target #(
      .WAIT (TGT_WAIT[k])
    ) u_bus_target (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .valid_i  (tgt_valid[k]),
      .addr_i   (core_addr_i),
      .wdata_i  (core_wdata_i),
      .wstrb_i  (core_wstrb_i),
      .rdata_o  (tgt_rdata[k]),
      .ready_o  (tgt_ready[k])
    );
  end

  bus_resp_merge u_bus_resp_merge (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .tgt_ready_i      (tgt_ready),
    .tgt_rdata_i      (tgt_rdata),
    .unmapped_valid_i (unmapped_valid),
    .core_ready_o     (core_ready_o),
    .core_rdata_o     (core_rdata_o)
  );

endmodule

`default_nettype wire

/* logic/bus_resp_merge.sv */
// response merger for target ready and read data, with unmapped responder

`timescale 1ns/10ps
`default_nettype none

`include "mmap_cfg.svh"

module bus_resp_merge
  import bus_types_pkg::*;
(
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  // target responses
  input  tgt_sel_t                 tgt_ready_i,
  input  data_t [`TGT_NUM-1:0]     tgt_rdata_i,
  // request that no region claims
  input  logic                     unmapped_valid_i,
  // back to the core
  output logic                     core_ready_o,
  output data_t                    core_rdata_o
);

  logic unmapped_ready_q;

  // one pulse per unmapped request
  // the pulse itself blocks a repeat in the cycle it is high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      unmapped_ready_q <= 1'b0;
    end else begin
      unmapped_ready_q <= unmapped_valid_i && !unmapped_ready_q;
    end
  end

  assign core_ready_o = (tgt_ready_i != '0) || unmapped_ready_q;

  // lowest target index wins, only one is ever ready
  always_comb begin
    core_rdata_o = '0;
    if (unmapped_ready_q) begin
      core_rdata_o = `UNMAPPED_RDATA;
    end
    for (int k = `TGT_NUM - 1; k >= 0; k--) begin
      if (tgt_ready_i[k]) begin
        core_rdata_o = tgt_rdata_i[k];
      end
    end
  end

endmodule

`default_nettype wire

/* logic/bus_target.sv */
// wait-state target with a register memory and byte-strobe writes

`timescale 1ns/10ps
`default_nettype none

`include "mmap_cfg.svh"

module bus_target
  import bus_types_pkg::*;
  import bus_target_pkg::*;
#(
  // wait cycles before the response cycle, up to 15
  parameter int unsigned WAIT = 0
) (
  input  logic  clk_i,
  input  logic  arst_n_i,
  // request from the decoder, held until ready
  input  logic  valid_i,
  input  addr_t addr_i,
  input  data_t wdata_i,
  input  strb_t wstrb_i,
  // response
  output data_t rdata_o,
  output logic  ready_o
);

  // counter start value, so that WAIT edges pass in TGT_WAIT
  localparam wait_cnt_t WAIT_LOAD = (WAIT > 0) ? wait_cnt_t'(WAIT - 1) : '0;

  tgt_state_e state_q;
  tgt_state_e state_d;
  wait_cnt_t  cnt_q;
  wait_cnt_t  cnt_d;
  word_idx_t  word_idx;
  logic       wr_en;
  data_t      mem_q [`TGT_DEPTH];

  assign word_idx = addr_i[7:2];

  // next state
  always_comb begin
    state_d = state_q;
    cnt_d   = cnt_q;
    unique case (state_q)
      TGT_IDLE: begin
        if (valid_i) begin
          if (WAIT == 0) begin
            state_d = TGT_RESP;
          end else begin
            state_d = TGT_WAIT;
            cnt_d   = WAIT_LOAD;
          end
        end
      end
      TGT_WAIT: begin
        if (cnt_q == '0) begin
          state_d = TGT_RESP;
        end else begin
          cnt_d = cnt_q - wait_cnt_t'(1);
        end
      end
      TGT_RESP: state_d = TGT_IDLE;
      default:  state_d = TGT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= TGT_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  // write lands at the edge that closes the response cycle
  assign wr_en = (state_q == TGT_RESP) && (wstrb_i != '0);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int i = 0; i < `TGT_DEPTH; i++) begin
        mem_q[i] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < 4; b++) begin
        if (wstrb_i[b]) begin
          mem_q[word_idx][8*b +: 8] <= wdata_i[8*b +: 8];
        end
      end
    end
  end

  // read path shows the word before any pending write
  assign rdata_o = mem_q[word_idx];
  assign ready_o = (state_q == TGT_RESP);

endmodule

`default_nettype wire

/* logic/bus_decode.sv */
// address decoder with one-hot region valid and unmapped access flag

`timescale 1ns/10ps
`default_nettype none

`include "mmap_cfg.svh"

module bus_decode
  import bus_types_pkg::*;
(
  // core request
  input  logic     core_valid_i,
  input  addr_t    core_addr_i,
  // one valid per target
  output tgt_sel_t tgt_valid_o,
  // request that hits no region
  output logic     unmapped_valid_o
);

  // region table, entry k is the base byte of target k
  localparam logic [7:0] REGION_BASE [`TGT_NUM] = '{
    `NATV_IP_START,
    `APB_START,
    `PSRAM_START,
    `SPISD_START
  };

  logic [7:0] top_byte;
  tgt_sel_t   region_hit;

  // only the top byte selects a region
  assign top_byte = core_addr_i[31:24];

  always_comb begin
    region_hit = '0;
    for (int k = 0; k < `TGT_NUM; k++) begin
      if (top_byte == REGION_BASE[k]) begin
        region_hit[k] = 1'b1;
      end
    end
  end

  // bases are distinct, so at most one bit is set
  assign tgt_valid_o = core_valid_i ? region_hit : '0;

  // nobody claims it, the merger answers instead
  assign unmapped_valid_o = core_valid_i && (region_hit == '0);

endmodule

`default_nettype wire

/* logic/bus_target_pkg.sv */
// package of target-side types, the target FSM states and wait counter

`default_nettype none

package bus_target_pkg;

  // idle, counting wait cycles, single response cycle
  typedef enum logic [1:0] {
    TGT_IDLE,
    TGT_WAIT,
    TGT_RESP
  } tgt_state_e;

  // wait counter, wide enough for 15 wait cycles
  typedef logic [3:0] wait_cnt_t;

endpackage

`default_nettype wire

/* logic/bus_types_pkg.sv */
// package of bus vector types shared by the fabric blocks

`default_nettype none

`include "mmap_cfg.svh"

package bus_types_pkg;

  // byte address from the core
  typedef logic [31:0] addr_t;

  // read and write data word
  typedef logic [31:0] data_t;

  // one bit per byte lane, all zero for a read
  typedef logic [3:0] strb_t;

  // word index inside one target
  typedef logic [5:0] word_idx_t;

  // one-hot select, one bit per target
  typedef logic [`TGT_NUM-1:0] tgt_sel_t;

endpackage

`default_nettype wire

/* include/mmap_cfg.svh */
// memory map, per-region wait counts and target sizing macros

`ifndef MMAP_CFG_SVH
`define MMAP_CFG_SVH

// top address byte of each region
// native ip region
`define NATV_IP_START 8'h10

// apb bridge region
`define APB_START 8'h20

// psram region
`define PSRAM_START 8'h30

// spi-sd region
`define SPISD_START 8'h40

// wait cycles each target inserts before its response cycle
`define NATV_WAIT 0
`define APB_WAIT 1
`define PSRAM_WAIT 3

// slowest target, the sd card stand-in
`define SPISD_WAIT 5

// number of targets behind the fabric
`define TGT_NUM 4

// words per target memory
// indexed by address bits 7:2
`define TGT_DEPTH 64

// read word for an address outside every region
`define UNMAPPED_RDATA 32'hdead_beef

`endif
